// ==== all.f ====
+incdir+.
rv_pkg.sv
rv_regfile.sv
rv_alu.sv
rv_lsu.sv
rv_dmem.sv
rv_exu.sv
rv_exec_top.sv
tb_clock.sv
tb_exec.sv

// ==== Bender.yml ====
package:
  name: rv_exec

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - rv_pkg.sv
      - rv_regfile.sv
      - rv_alu.sv
      - rv_lsu.sv
      - rv_dmem.sv
      - rv_exu.sv
      - rv_exec_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock.sv
      - tb_exec.sv

// ==== tb_exec.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "rv_settings.svh"

module tb_exec;
  import rv_pkg::*;

  localparam int N_BASIC = 34;
  localparam int N_CTRL = 12;
  localparam int N_MEM = 2 + 4 * 8 * 6;
  localparam int N_RAND = 300;
  localparam int N_CHAIN = 24;
  localparam int N_HALT = 4;
  localparam int N_INSTR = N_BASIC + N_CTRL + N_MEM + N_RAND + N_CHAIN + N_HALT;
  localparam int MAX_CYCLES = 4 * N_INSTR + 100;

  logic        clk;
  logic        reset;
  logic        in_valid;
  rv_instr_t   in_instr;
  logic        retire_valid;
  rv_retire_t  retire;

  logic [`RV_XLEN-1:0] model_regs [`RV_NREGS];
  logic [`RV_XLEN-1:0] model_mem [int];
  rv_retire_t          exp_q [$];
  logic [`RV_XLEN-1:0] pc_model;
  logic                retire_due;
  int unsigned         n_issued;
  int unsigned         n_retired;
  int unsigned         cycle_count;

  rv_op_e alu_ops [20] = '{ADD, SUB, AND, OR, XOR, SLT, SLTU, SLL, SRL, SRA, ADDW, SUBW,
                           SLLW, ADDI, ANDI, XORI, SLTIU, SLLI, SRAI, ADDIW};
  rv_op_e store_ops [4] = '{SD, SW, SH, SB};

  tb_clock #(.PERIOD_NS(20), .RESET_CYCLES(2)) i_clock (
    .clk   (clk),
    .reset (reset)
  );

  rv_exec_top i_rv_exec_top (
    .clk          (clk),
    .reset        (reset),
    .in_valid     (in_valid),
    .in_instr     (in_instr),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  task automatic stop_on_failure();
    $display("Errors found");
    $fatal(1, "stopping at the first failure");
  endtask

  function automatic logic [63:0] sext32(input logic [31:0] v);
    return {{32{v[31]}}, v};
  endfunction

  // unwritten words read as unknown, like the real memory
  function automatic logic [63:0] mem_word(input logic [63:0] addr);
    int idx;
    idx = int'(addr[11:3]);
    return model_mem.exists(idx) ? model_mem[idx] : 'x;
  endfunction

  // expected retire record, model state moves on as the instruction commits
  function automatic rv_retire_t model_exec(input rv_instr_t ins);
    rv_retire_t  want;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] res;
    logic [63:0] addr;
    logic [63:0] word;
    logic        writes;
    int          size;
    int          lane;
    a = model_regs[ins.rs1];
    b = model_regs[ins.rs2];
    addr = a + ins.imm;
    res = '0;
    writes = 1'b1;
    size = 0;
    want = '0;
    want.pc = ins.pc;
    want.next_pc = ins.pc + 64'd4;
    want.rd = ins.rd;
    case (ins.op)
      ADD:    res = a + b;
      SUB:    res = a - b;
      AND:    res = a & b;
      OR:     res = a | b;
      XOR:    res = a ^ b;
      SLT:    res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      SLTU:   res = (a < b) ? 64'd1 : 64'd0;
      SLL:    res = a << b[5:0];
      SRL:    res = a >> b[5:0];
      SRA:    res = $signed(a) >>> b[5:0];
      ADDW:   res = sext32(a[31:0] + b[31:0]);
      SUBW:   res = sext32(a[31:0] - b[31:0]);
      SLLW:   res = sext32(a[31:0] << b[4:0]);
      ADDI:   res = a + ins.imm;
      ANDI:   res = a & ins.imm;
      XORI:   res = a ^ ins.imm;
      SLTIU:  res = (a < ins.imm) ? 64'd1 : 64'd0;
      SLLI:   res = a << ins.imm[5:0];
      SRAI:   res = $signed(a) >>> ins.imm[5:0];
      ADDIW:  res = sext32(a[31:0] + ins.imm[31:0]);
      LUI:    res = ins.imm;
      AUIPC:  res = ins.pc + ins.imm;
      JAL: begin
        res = ins.pc + 64'd4;
        want.next_pc = ins.pc + ins.imm;
      end
      JALR: begin
        res = ins.pc + 64'd4;
        want.next_pc = addr & ~64'd1;
      end
      BEQ, BNE: begin
        writes = 1'b0;
        if ((a == b) == (ins.op == BEQ)) want.next_pc = ins.pc + ins.imm;
      end
      LD:     res = mem_word(addr);
      LW: begin
        word = mem_word(addr);
        res = addr[2] ? sext32(word[63:32]) : sext32(word[31:0]);
      end
      LBU: begin
        word = mem_word(addr);
        res = {56'd0, word[addr[2:0] * 8 +: 8]};
      end
      SD:     size = 8;
      SW:     size = 4;
      SH:     size = 2;
      SB:     size = 1;
      EBREAK: begin
        writes = 1'b0;
        want.halt = 1'b1;
        want.halt_fail = (model_regs[10] != 64'd0);
      end
      default: writes = 1'b0;
    endcase
    if (size > 0) begin
      writes = 1'b0;
      word = mem_word(addr);
      // bytes past the end of the word are lost
      for (int k = 0; k < size; k++) begin
        lane = int'(addr[2:0]) + k;
        if (lane < 8) word[lane * 8 +: 8] = b[k * 8 +: 8];
      end
      model_mem[int'(addr[11:3])] = word;
    end
    if (writes && ins.rd != 5'd0) begin
      want.wen = 1'b1;
      want.wdata = res;
      model_regs[ins.rd] = res;
    end
    return want;
  endfunction

  task automatic issue(input rv_op_e op, input logic [4:0] rd, input logic [4:0] rs1,
                       input logic [4:0] rs2, input logic [63:0] imm);
    rv_instr_t ins;
    rv_retire_t want;
    ins.op = op;
    ins.rd = rd;
    ins.rs1 = rs1;
    ins.rs2 = rs2;
    ins.imm = imm;
    ins.pc = pc_model;
    @(negedge clk);
    in_valid = 1'b1;
    in_instr = ins;
    want = model_exec(ins);
    exp_q.push_back(want);
    pc_model = want.next_pc;
    n_issued++;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      in_valid = 1'b0;
    end
  endtask

  task automatic check_retire(input rv_retire_t got, input rv_retire_t want);
    if (got !== want) begin
      $display("ERROR at %0t: retire of pc %h does not match", $time, want.pc);
      $display("  got      next_pc %h rd %0d wen %b wdata %h halt %b fail %b",
               got.next_pc, got.rd, got.wen, got.wdata, got.halt, got.halt_fail);
      $display("  expected next_pc %h rd %0d wen %b wdata %h halt %b fail %b",
               want.next_pc, want.rd, want.wen, want.wdata, want.halt, want.halt_fail);
      stop_on_failure();
    end
  endtask

  task automatic check_count(input int unsigned got, input int unsigned want,
                             input string what);
    if (got != want) begin
      $display("ERROR at %0t: %s is %0d, expected %0d", $time, what, got, want);
      stop_on_failure();
    end
  endtask

  // an instruction taken at this edge retires in the next cycle
  always @(posedge clk) begin
    retire_due <= in_valid;
  end

  // retire outputs are registered, so the falling edge sees them settled
  always @(negedge clk) begin
    if (!reset) begin
      if (retire_valid !== retire_due) begin
        $display("ERROR at %0t: retire_valid is %b, expected %b", $time, retire_valid,
                 retire_due);
        stop_on_failure();
      end else if (retire_valid && exp_q.size() == 0) begin
        $display("a retire strobe came with no instruction outstanding at %0t", $time);
        stop_on_failure();
      end else if (retire_valid) begin
        check_retire(retire, exp_q.pop_front());
        n_retired++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("the run did not finish within %0d cycles", MAX_CYCLES);
      stop_on_failure();
    end
  end

  initial begin
    logic [63:0] disp;
    logic [31:0] r;
    void'($urandom(32'h8ca5_3c07));
    in_valid = 1'b0;
    in_instr = '0;
    pc_model = 64'h8000_0000;
    n_issued = 0;
    n_retired = 0;
    cycle_count = 0;
    foreach (model_regs[i]) model_regs[i] = '0;
    wait (reset == 1'b0);

    // quiet after reset, then every register reads zero
    idle_cycles(5);
    check_count(n_retired, 0, "retires with no input");
    for (int i = 0; i < 32; i++) begin
      issue(ADD, 5'(i), 5'(i), 5'(i), 64'd0);
    end
    issue(ADDI, 5'd0, 5'd0, 5'd0, 64'd123);
    issue(ADD, 5'd1, 5'd0, 5'd0, 64'd0);

    // jumps and branches
    issue(ADDI, 5'd6, 5'd0, 5'd0, 64'h100);
    issue(ADDI, 5'd7, 5'd0, 5'd0, 64'd5);
    issue(ADDI, 5'd8, 5'd0, 5'd0, 64'd5);
    issue(ADDI, 5'd9, 5'd0, 5'd0, -64'sd3);
    issue(LUI, 5'd11, 5'd0, 5'd0, 64'hffff_ffff_8765_4000);
    issue(AUIPC, 5'd12, 5'd0, 5'd0, 64'h2000);
    issue(JAL, 5'd1, 5'd0, 5'd0, -64'sd64);
    issue(JALR, 5'd1, 5'd6, 5'd0, 64'h23);
    issue(BEQ, 5'd0, 5'd7, 5'd8, 64'h10);
    issue(BEQ, 5'd0, 5'd7, 5'd9, 64'h10);
    issue(BNE, 5'd0, 5'd7, 5'd9, -64'sd8);
    issue(BNE, 5'd0, 5'd7, 5'd8, -64'sd8);

    // every store width at every byte offset, read back three ways
    issue(LUI, 5'd20, 5'd0, 5'd0, 64'h0123_4567_89ab_cdef);
    issue(LUI, 5'd22, 5'd0, 5'd0, 64'h100);
    for (int w = 0; w < 4; w++) begin
      for (int off = 0; off < 8; off++) begin
        disp = 64'((w * 8 + off) * 8);
        issue(LUI, 5'd21, 5'd0, 5'd0, {$urandom, $urandom});
        issue(SD, 5'd0, 5'd22, 5'd20, disp);
        issue(store_ops[w], 5'd0, 5'd22, 5'd21, disp + 64'(off));
        issue(LD, 5'd14, 5'd22, 5'd0, disp);
        issue(LW, 5'd15, 5'd22, 5'd0, disp + 64'(off));
        issue(LBU, 5'd16, 5'd22, 5'd0, disp + 64'(off));
      end
    end

    for (int i = 0; i < N_RAND; i++) begin
      r = $urandom;
      issue(alu_ops[$urandom % 20], 5'($urandom), 5'($urandom), 5'($urandom),
            {{52{r[11]}}, r[11:0]});
    end

    // dependent chain through x5
    issue(LUI, 5'd5, 5'd0, 5'd0, 64'h0000_0001_2345_6789);
    for (int i = 0; i < 20; i++) begin
      case (i % 4)
        0:       issue(ADDI, 5'd5, 5'd5, 5'd0, 64'(i + 1));
        1:       issue(SLLI, 5'd5, 5'd5, 5'd0, 64'd3);
        2:       issue(XOR, 5'd5, 5'd5, 5'd20, 64'd0);
        default: issue(ADDW, 5'd5, 5'd5, 5'd5, 64'd0);
      endcase
    end
    issue(SD, 5'd0, 5'd0, 5'd5, 64'h300);
    issue(LD, 5'd13, 5'd0, 5'd0, 64'h300);
    issue(ADD, 5'd5, 5'd13, 5'd5, 64'd0);

    issue(ADDI, 5'd10, 5'd0, 5'd0, 64'd0);
    issue(EBREAK, 5'd0, 5'd0, 5'd0, 64'd0);
    issue(ADDI, 5'd10, 5'd0, 5'd0, 64'd7);
    issue(EBREAK, 5'd0, 5'd0, 5'd0, 64'd0);

    idle_cycles(2);
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    check_count(n_retired, n_issued, "retired instructions");
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_clock.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

`default_nettype wire

// ==== rv_exec_top.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "rv_settings.svh"

module rv_exec_top (
  input  wire                    clk,
  input  wire                    reset,
  input  wire                    in_valid,
  input  wire rv_pkg::rv_instr_t in_instr,
  output logic                   retire_valid,
  output rv_pkg::rv_retire_t     retire
);
  import rv_pkg::*;

  rv_mem_req_t         mem_req;
  logic                mem_en;
  logic [`RV_XLEN-1:0] mem_rdata;

  rv_exu i_exu (
    .clk          (clk),
    .reset        (reset),
    .in_valid     (in_valid),
    .in_instr     (in_instr),
    .mem_rdata    (mem_rdata),
    .mem_req      (mem_req),
    .mem_en       (mem_en),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  // read data returns in the same cycle
  rv_dmem i_dmem (
    .clk   (clk),
    .req   (mem_req),
    .en    (mem_en),
    .rdata (mem_rdata)
  );

endmodule

`default_nettype wire

// ==== rv_exu.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "rv_settings.svh"

module rv_exu (
  input  wire                    clk,
  input  wire                    reset,
  input  wire                    in_valid,
  input  wire rv_pkg::rv_instr_t in_instr,
  input  wire [`RV_XLEN-1:0]     mem_rdata,
  output rv_pkg::rv_mem_req_t    mem_req,
  output logic                   mem_en,
  output logic                   retire_valid,
  output rv_pkg::rv_retire_t     retire
);
  import rv_pkg::*;

  typedef enum logic [1:0] {WB_ALU, WB_IMM, WB_LINK, WB_LOAD} wb_sel_e;

  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic [`RV_XLEN-1:0] a0_data;
  logic [`RV_XLEN-1:0] alu_a;
  logic [`RV_XLEN-1:0] alu_b;
  logic [`RV_XLEN-1:0] alu_y;
  logic [`RV_XLEN-1:0] st_wdata;
  logic [7:0]          st_wmask;
  logic [`RV_XLEN-1:0] load_val;
  logic [`RV_XLEN-1:0] link_pc;
  logic [`RV_XLEN-1:0] branch_pc;
  logic [`RV_XLEN-1:0] next_pc;
  logic [`RV_XLEN-1:0] wb_data;
  rv_alu_mode_e        alu_mode;
  wb_sel_e             wb_sel;
  logic                alu_word;
  logic                a_is_pc;
  logic                b_is_imm;
  logic                rd_write;
  logic                is_store;
  logic                is_halt;
  logic                br_taken;
  logic                wen;
  rv_retire_t          retire_d;

  always_comb begin
    case (in_instr.op)
      SUB, SUBW:         alu_mode = ALU_SUB;
      AND, ANDI:         alu_mode = ALU_AND;
      OR:                alu_mode = ALU_OR;
      XOR, XORI:         alu_mode = ALU_XOR;
      SLT:               alu_mode = ALU_SLT;
      SLTU, SLTIU:       alu_mode = ALU_SLTU;
      SLL, SLLW, SLLI:   alu_mode = ALU_SLL;
      SRL:               alu_mode = ALU_SRL;
      SRA, SRAI:         alu_mode = ALU_SRA;
      BEQ, BNE:          alu_mode = ALU_EQ;
      // address and link sums too
      default:           alu_mode = ALU_ADD;
    endcase
  end

  assign alu_word = in_instr.op inside {ADDW, SUBW, SLLW, ADDIW};
  assign a_is_pc  = in_instr.op inside {AUIPC, JAL};
  assign b_is_imm = !(in_instr.op inside {ADD, SUB, AND, OR, XOR, SLT, SLTU, SLL, SRL,
                                          SRA, ADDW, SUBW, SLLW, BEQ, BNE});
  assign is_store = in_instr.op inside {SD, SW, SH, SB};
  assign is_halt  = in_instr.op == EBREAK;
  assign rd_write = !(is_store || is_halt || in_instr.op inside {BEQ, BNE});

  always_comb begin
    case (in_instr.op)
      LUI:          wb_sel = WB_IMM;
      JAL, JALR:    wb_sel = WB_LINK;
      LD, LW, LBU:  wb_sel = WB_LOAD;
      default:      wb_sel = WB_ALU;
    endcase
  end

  rv_regfile i_regfile (
    .clk    (clk),
    .reset  (reset),
    .raddr1 (in_instr.rs1),
    .raddr2 (in_instr.rs2),
    .waddr  (in_instr.rd),
    .wen    (wen),
    .wdata  (wb_data),
    .rdata1 (rs1_data),
    .rdata2 (rs2_data),
    .a0     (a0_data)
  );

  assign alu_a = a_is_pc ? in_instr.pc : rs1_data;
  assign alu_b = b_is_imm ? in_instr.imm : rs2_data;

  rv_alu i_alu (
    .mode (alu_mode),
    .word (alu_word),
    .a    (alu_a),
    .b    (alu_b),
    .y    (alu_y)
  );

  // loads and stores address through the alu sum
  rv_lsu i_lsu (
    .op        (in_instr.op),
    .addr      (alu_y),
    .store_src (rs2_data),
    .rdata     (mem_rdata),
    .wdata     (st_wdata),
    .wmask     (st_wmask),
    .load_val  (load_val)
  );

  always_comb begin
    mem_req.addr  = alu_y;
    mem_req.wdata = st_wdata;
    mem_req.wmask = st_wmask;
    mem_req.we    = is_store;
  end

  assign mem_en = in_valid;

  assign link_pc   = in_instr.pc + `RV_XLEN'(4);
  assign branch_pc = in_instr.pc + in_instr.imm;

  // eq result sits in bit 0
  assign br_taken = (in_instr.op == BEQ && alu_y[0]) || (in_instr.op == BNE && !alu_y[0]);

  always_comb begin
    case (in_instr.op)
      JAL:     next_pc = alu_y;
      JALR:    next_pc = {alu_y[`RV_XLEN-1:1], 1'b0};
      default: next_pc = br_taken ? branch_pc : link_pc;
    endcase
  end

  always_comb begin
    case (wb_sel)
      WB_IMM:  wb_data = in_instr.imm;
      WB_LINK: wb_data = link_pc;
      WB_LOAD: wb_data = load_val;
      default: wb_data = alu_y;
    endcase
  end

  assign wen = in_valid && rd_write && (in_instr.rd != '0);

  always_comb begin
    retire_d.pc        = in_instr.pc;
    retire_d.next_pc   = next_pc;
    retire_d.rd        = in_instr.rd;
    retire_d.wen       = wen;
    retire_d.wdata     = wen ? wb_data : '0;
    retire_d.halt      = is_halt;
    retire_d.halt_fail = is_halt && (a0_data != '0);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      retire <= retire_d;
    end
  end

endmodule

`default_nettype wire

// ==== rv_dmem.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "rv_settings.svh"

module rv_dmem (
  input  wire                      clk,
  input  wire rv_pkg::rv_mem_req_t req,
  input  wire                      en,
  output logic [`RV_XLEN-1:0]      rdata
);

  localparam int AW = $clog2(`RV_DMEM_WORDS);

  logic [`RV_XLEN-1:0] mem [`RV_DMEM_WORDS];
  logic [AW-1:0]       index;

  // word index, byte offset dropped
  assign index = req.addr[AW+2:3];

  assign rdata = mem[index];

  always_ff @(posedge clk) begin
    if (en && req.we) begin
      for (int i = 0; i < `RV_XLEN/8; i++) begin
        if (req.wmask[i]) begin
          mem[index][i*8 +: 8] <= req.wdata[i*8 +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== rv_lsu.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "rv_settings.svh"

module rv_lsu (
  input  wire rv_pkg::rv_op_e  op,
  input  wire [`RV_XLEN-1:0]   addr,
  input  wire [`RV_XLEN-1:0]   store_src,
  input  wire [`RV_XLEN-1:0]   rdata,
  output logic [`RV_XLEN-1:0]  wdata,
  output logic [7:0]           wmask,
  output logic [`RV_XLEN-1:0]  load_val
);
  import rv_pkg::*;

  logic [5:0]  lane_shift;
  logic [7:0]  size_mask;
  logic [31:0] word_sel;
  logic [7:0]  byte_sel;

  // byte offset within the word, in bits
  assign lane_shift = {addr[2:0], 3'b000};

  always_comb begin
    case (op)
      SD:      size_mask = 8'hff;
      SW:      size_mask = 8'h0f;
      SH:      size_mask = 8'h03;
      SB:      size_mask = 8'h01;
      default: size_mask = 8'h00;
    endcase
  end

  // data moves to its lane, the mask follows it
  assign wdata = store_src << lane_shift;
  assign wmask = size_mask << addr[2:0];

  assign word_sel = addr[2] ? rdata[63:32] : rdata[31:0];
  assign byte_sel = rdata[lane_shift +: 8];

  always_comb begin
    case (op)
      LD:      load_val = rdata;
      LW:      load_val = {{(`RV_XLEN-32){word_sel[31]}}, word_sel};
      LBU:     load_val = {{(`RV_XLEN-8){1'b0}}, byte_sel};
      default: load_val = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== rv_alu.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "rv_settings.svh"

module rv_alu (
  input  wire rv_pkg::rv_alu_mode_e mode,
  input  wire                       word,
  input  wire [`RV_XLEN-1:0]        a,
  input  wire [`RV_XLEN-1:0]        b,
  output logic [`RV_XLEN-1:0]       y
);
  import rv_pkg::*;

  localparam int SHW = $clog2(`RV_XLEN);

  logic [SHW-1:0]      shamt;
  logic [`RV_XLEN-1:0] a_srl;
  logic [`RV_XLEN-1:0] a_sra;
  logic [`RV_XLEN-1:0] r;

  // word shifts take 5 bits of shift amount
  assign shamt = word ? SHW'(b[4:0]) : b[SHW-1:0];

  // right shifts of a word only see the low half of a
  assign a_srl = word ? {{(`RV_XLEN-32){1'b0}}, a[31:0]} : a;
  assign a_sra = word ? {{(`RV_XLEN-32){a[31]}}, a[31:0]} : a;

  always_comb begin
    case (mode)
      ALU_ADD:  r = a + b;
      ALU_SUB:  r = a - b;
      ALU_AND:  r = a & b;
      ALU_OR:   r = a | b;
      ALU_XOR:  r = a ^ b;
      ALU_SLT:  r = `RV_XLEN'($signed(a) < $signed(b));
      ALU_SLTU: r = `RV_XLEN'(a < b);
      ALU_SLL:  r = a << shamt;
      ALU_SRL:  r = a_srl >> shamt;
      ALU_SRA:  r = `RV_XLEN'($signed(a_sra) >>> shamt);
      ALU_EQ:   r = `RV_XLEN'(a == b);
      default:  r = '0;
    endcase
  end

  // word results sign-extend from bit 31
  assign y = word ? {{(`RV_XLEN-32){r[31]}}, r[31:0]} : r;

endmodule

`default_nettype wire

// ==== rv_regfile.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "rv_settings.svh"

module rv_regfile (
  input  wire                         clk,
  input  wire                         reset,
  input  wire [$clog2(`RV_NREGS)-1:0] raddr1,
  input  wire [$clog2(`RV_NREGS)-1:0] raddr2,
  input  wire [$clog2(`RV_NREGS)-1:0] waddr,
  input  wire                         wen,
  input  wire [`RV_XLEN-1:0]          wdata,
  output logic [`RV_XLEN-1:0]         rdata1,
  output logic [`RV_XLEN-1:0]         rdata2,
  output logic [`RV_XLEN-1:0]         a0
);

  // x0 has no storage
  logic [`RV_XLEN-1:0] regs [1:`RV_NREGS-1];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

  // x10 for the halt code
  assign a0 = regs[10];

endmodule

`default_nettype wire

// ==== rv_pkg.sv ====
`default_nettype none
`include "rv_settings.svh"

package rv_pkg;

  // decoded operation, one value per supported instruction
  typedef enum logic [5:0] {
    // register forms
    ADD, SUB, AND, OR, XOR, SLT, SLTU, SLL, SRL, SRA,
    ADDW, SUBW, SLLW,
    // immediate forms
    ADDI, ANDI, XORI, SLTIU, SLLI, SRAI, ADDIW,
    // upper immediates
    LUI, AUIPC,
    // control transfer
    JAL, JALR, BEQ, BNE,
    // loads
    LD, LW, LBU,
    // stores
    SD, SW, SH, SB,
    EBREAK
  } rv_op_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_EQ
  } rv_alu_mode_e;

  // imm arrives already selected and sign-extended
  typedef struct packed {
    rv_op_e                      op;
    logic [$clog2(`RV_NREGS)-1:0] rd;
    logic [$clog2(`RV_NREGS)-1:0] rs1;
    logic [$clog2(`RV_NREGS)-1:0] rs2;
    logic [`RV_XLEN-1:0]         imm;
    logic [`RV_XLEN-1:0]         pc;
  } rv_instr_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0]   addr;
    logic [`RV_XLEN-1:0]   wdata;
    logic [`RV_XLEN/8-1:0] wmask;
    logic                  we;
  } rv_mem_req_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0]         pc;
    logic [`RV_XLEN-1:0]         next_pc;
    logic [$clog2(`RV_NREGS)-1:0] rd;
    logic                        wen;
    logic [`RV_XLEN-1:0]         wdata;
    logic                        halt;
    // a0 was nonzero at ebreak
    logic                        halt_fail;
  } rv_retire_t;

endpackage

`default_nettype wire

// ==== rv_settings.svh ====
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// data and address width
`define RV_XLEN 64

// integer register count, x0 included
`define RV_NREGS 32

// data memory depth in XLEN-wide words
`define RV_DMEM_WORDS 512

`endif
